// File: io_tile_mem_pkg.sv
// Memory message package
// Uncached command and response format shared by the dispatcher, the local
// devices and the off-tile memory port. Every access is one 64-bit word.

`default_nettype none

package io_tile_mem_pkg;

  // Physical address and data word widths
  localparam int ADDR_W = 40;
  localparam int DATA_W = 64;

  // Uncached word opcodes
  typedef enum logic [0:0]
  {
    e_mem_uc_rd   = 1'b0
    , e_mem_uc_wr = 1'b1
  } mem_op_e;

  // Same layout for commands and responses
  // Response echoes op and addr; data is zero for a write
  typedef struct packed
  {
    mem_op_e             op;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   data;
  } mem_msg_s;

endpackage

`default_nettype wire

// File: io_tile_map_pkg.sv
// Local memory map package
// Address map of the tile, device codes, register offsets of the
// configuration block and the CLINT slice, and the cfg bus layout.

`default_nettype none

package io_tile_map_pkg;

  // Addresses below this are local to the tile
  localparam logic [31:0] LOCAL_LIMIT = 32'h8000_0000;

  // Device select field of a local address
  localparam int DEV_LSB = 20;
  localparam int DEV_W   = 4;

  typedef enum logic [DEV_W-1:0]
  {
    e_dev_host    = 4'd0
    , e_dev_clint = 4'd1
    , e_dev_cfg   = 4'd2
    , e_dev_cache = 4'd3
  } dev_e;

  // Register offsets, low address bits only
  localparam int OFS_W = 16;

  localparam logic [OFS_W-1:0] CFG_FREEZE_OFS  = 16'h0000;
  localparam logic [OFS_W-1:0] CFG_CORE_ID_OFS = 16'h0008;
  localparam logic [OFS_W-1:0] CFG_MODE_OFS    = 16'h0010;

  localparam logic [OFS_W-1:0] CLINT_MSIP_OFS     = 16'h0000;
  localparam logic [OFS_W-1:0] CLINT_MTIMECMP_OFS = 16'h4000;
  localparam logic [OFS_W-1:0] CLINT_MTIME_OFS    = 16'hBFF8;

  // Clock cycles per mtime tick
  localparam int MTIME_DIV = 8;

  localparam int CORE_ID_W = 8;

  typedef struct packed
  {
    logic                 freeze;
    logic [CORE_ID_W-1:0] core_id;
    logic                 cce_mode;
  } cfg_bus_s;

endpackage

`default_nettype wire

// File: io_slave_fsm.sv
// Local device slave FSM
// Single-entry command/response control for a local device. Accepts one
// command, pulses accept_o on that edge and holds the response valid
// until the requester grants it with yumi.

`timescale 1ns/100ps
`default_nettype none

module io_slave_fsm
  (input    logic clk_i
   , input  logic rst_i

   , input  logic cmd_v_i
   , output logic cmd_ready_o
   , output logic accept_o

   , output logic resp_v_o
   , input  logic resp_yumi_i
   );

  typedef enum logic [0:0]
  {
    e_idle   = 1'b0
    , e_resp = 1'b1
  } slave_state_e;

  slave_state_e state_r;
  slave_state_e state_n;

  // Busy while a response waits, which stalls the whole command port
  assign cmd_ready_o = (state_r == e_idle);
  assign accept_o    = cmd_v_i & cmd_ready_o;
  assign resp_v_o    = (state_r == e_resp);

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_idle:
        if (accept_o)
          state_n = e_resp;
      e_resp:
        if (resp_yumi_i)
          state_n = e_idle;
      default:
        state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      state_r <= e_idle;
    else
      state_r <= state_n;
  end

endmodule

`default_nettype wire

// File: mtime_counter.sv
// Machine timer
// 64-bit mtime that advances once every MTIME_DIV clocks. A load replaces
// the time value and restarts the prescaler.

`timescale 1ns/100ps
`default_nettype none

module mtime_counter
  import io_tile_mem_pkg::*;
  import io_tile_map_pkg::*;
  (input    logic              clk_i
   , input  logic              rst_i

   , input  logic              load_i
   , input  logic [DATA_W-1:0] load_data_i
   , output logic [DATA_W-1:0] mtime_o
   );

  typedef logic [$clog2(MTIME_DIV)-1:0] div_cnt_t;

  div_cnt_t          div_cnt_r;
  logic              tick;
  logic [DATA_W-1:0] mtime_r;

  assign tick = (div_cnt_r == div_cnt_t'(MTIME_DIV - 1));

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      div_cnt_r <= '0;
      mtime_r   <= '0;
    end
    else if (load_i)
    begin
      div_cnt_r <= '0;
      mtime_r   <= load_data_i;
    end
    else
    begin
      div_cnt_r <= tick ? '0 : div_cnt_r + 1'b1;
      if (tick)
        mtime_r <= mtime_r + 1'b1;
    end
  end

  assign mtime_o = mtime_r;

endmodule

`default_nettype wire

// File: mem_cmd_dispatch.sv
// Memory command dispatcher
// Decodes each uncached command by address and routes it to the cfg
// block, the CLINT slice or the off-tile memory port. Responses return
// through a fixed-priority arbiter: memory, then cfg, then clint.

`timescale 1ns/100ps
`default_nettype none

module mem_cmd_dispatch
  import io_tile_mem_pkg::*;
  import io_tile_map_pkg::*;
  (input    mem_msg_s cmd_i
   , input  logic     cmd_v_i
   , output logic     cmd_ready_o

   , output logic     cfg_cmd_v_o
   , input  logic     cfg_ready_i
   , output logic     clint_cmd_v_o
   , input  logic     clint_ready_i

   , output mem_msg_s mem_cmd_o
   , output logic     mem_cmd_v_o
   , input  logic     mem_cmd_ready_i

   , input  mem_msg_s cfg_resp_i
   , input  logic     cfg_resp_v_i
   , output logic     cfg_resp_yumi_o
   , input  mem_msg_s clint_resp_i
   , input  logic     clint_resp_v_i
   , output logic     clint_resp_yumi_o
   , input  mem_msg_s mem_resp_i
   , input  logic     mem_resp_v_i
   , output logic     mem_resp_yumi_o

   , output mem_msg_s resp_o
   , output logic     resp_v_o
   , input  logic     resp_yumi_i
   );

  logic is_local;
  dev_e dev;
  logic to_cfg;
  logic to_clint;

  assign is_local = (cmd_i.addr < ADDR_W'(LOCAL_LIMIT));
  assign dev      = dev_e'(cmd_i.addr[DEV_LSB +: DEV_W]);
  assign to_cfg   = is_local & (dev == e_dev_cfg);
  assign to_clint = is_local & (dev == e_dev_clint);

  assign cmd_ready_o = cfg_ready_i & clint_ready_i & mem_cmd_ready_i;

  // A target only sees valid when the other two can also take the command,
  // so no target accepts a command the port has not transferred
  assign cfg_cmd_v_o   = cmd_v_i & to_cfg & clint_ready_i & mem_cmd_ready_i;
  assign clint_cmd_v_o = cmd_v_i & to_clint & cfg_ready_i & mem_cmd_ready_i;
  assign mem_cmd_v_o   = cmd_v_i & ~to_cfg & ~to_clint & cfg_ready_i & clint_ready_i;

  // Non-local traffic leaves unchanged
  assign mem_cmd_o = cmd_i;

  assign resp_v_o = mem_resp_v_i | cfg_resp_v_i | clint_resp_v_i;
  assign resp_o   = mem_resp_v_i ? mem_resp_i
                  : cfg_resp_v_i ? cfg_resp_i
                  : clint_resp_i;

  // Grant goes to the shown source only
  assign mem_resp_yumi_o   = resp_yumi_i & mem_resp_v_i;
  assign cfg_resp_yumi_o   = resp_yumi_i & cfg_resp_v_i & ~mem_resp_v_i;
  assign clint_resp_yumi_o = resp_yumi_i & clint_resp_v_i & ~mem_resp_v_i & ~cfg_resp_v_i;

endmodule

`default_nettype wire

// File: cfg_regs.sv
// Configuration register block
// Holds freeze, core id and coherence mode and drives them on the cfg bus.
// One command at a time, with a registered response.

`timescale 1ns/100ps
`default_nettype none

module cfg_regs
  import io_tile_mem_pkg::*;
  import io_tile_map_pkg::*;
  (input    logic     clk_i
   , input  logic     rst_i

   , input  mem_msg_s cmd_i
   , input  logic     cmd_v_i
   , output logic     cmd_ready_o

   , output mem_msg_s resp_o
   , output logic     resp_v_o
   , input  logic     resp_yumi_i

   , output cfg_bus_s cfg_bus_o
   );

  logic              accept;
  logic              is_wr;
  logic [OFS_W-1:0]  ofs;
  logic [DATA_W-1:0] rd_data;
  cfg_bus_s          cfg_r;

  io_slave_fsm fsm_i
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.cmd_v_i(cmd_v_i)
     ,.cmd_ready_o(cmd_ready_o)
     ,.accept_o(accept)
     ,.resp_v_o(resp_v_o)
     ,.resp_yumi_i(resp_yumi_i)
     );

  assign is_wr = (cmd_i.op == e_mem_uc_wr);
  assign ofs   = cmd_i.addr[OFS_W-1:0];

  always_comb
  begin
    case (ofs)
      CFG_FREEZE_OFS:  rd_data = DATA_W'(cfg_r.freeze);
      CFG_CORE_ID_OFS: rd_data = DATA_W'(cfg_r.core_id);
      CFG_MODE_OFS:    rd_data = DATA_W'(cfg_r.cce_mode);
      default:         rd_data = '0;
    endcase
  end

  // Core comes up frozen
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      cfg_r <= '{freeze: 1'b1, core_id: '0, cce_mode: 1'b0};
    else if (accept & is_wr)
    begin
      case (ofs)
        CFG_FREEZE_OFS:  cfg_r.freeze   <= cmd_i.data[0];
        CFG_CORE_ID_OFS: cfg_r.core_id  <= cmd_i.data[CORE_ID_W-1:0];
        CFG_MODE_OFS:    cfg_r.cce_mode <= cmd_i.data[0];
        default:         cfg_r          <= cfg_r;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_o.op   <= cmd_i.op;
      resp_o.addr <= cmd_i.addr;
      resp_o.data <= is_wr ? '0 : rd_data;
    end
  end

  assign cfg_bus_o = cfg_r;

endmodule

`default_nettype wire

// File: clint_slice.sv
// CLINT slice
// Per-tile mtime, mtimecmp and msip registers behind the uncached command
// port. Raises the timer interrupt when mtime reaches mtimecmp and the
// software interrupt from msip bit 0.

`timescale 1ns/100ps
`default_nettype none

module clint_slice
  import io_tile_mem_pkg::*;
  import io_tile_map_pkg::*;
  (input    logic     clk_i
   , input  logic     rst_i

   , input  mem_msg_s cmd_i
   , input  logic     cmd_v_i
   , output logic     cmd_ready_o

   , output mem_msg_s resp_o
   , output logic     resp_v_o
   , input  logic     resp_yumi_i

   , output logic     timer_irq_o
   , output logic     software_irq_o
   );

  logic              accept;
  logic              is_wr;
  logic [OFS_W-1:0]  ofs;
  logic              mtime_load;
  logic [DATA_W-1:0] mtime;
  logic [DATA_W-1:0] mtimecmp_r;
  logic              msip_r;
  logic [DATA_W-1:0] rd_data;

  io_slave_fsm fsm_i
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.cmd_v_i(cmd_v_i)
     ,.cmd_ready_o(cmd_ready_o)
     ,.accept_o(accept)
     ,.resp_v_o(resp_v_o)
     ,.resp_yumi_i(resp_yumi_i)
     );

  assign is_wr      = (cmd_i.op == e_mem_uc_wr);
  assign ofs        = cmd_i.addr[OFS_W-1:0];
  assign mtime_load = accept & is_wr & (ofs == CLINT_MTIME_OFS);

  mtime_counter mtime_i
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.load_i(mtime_load)
     ,.load_data_i(cmd_i.data)
     ,.mtime_o(mtime)
     );

  always_comb
  begin
    case (ofs)
      CLINT_MSIP_OFS:     rd_data = DATA_W'(msip_r);
      CLINT_MTIMECMP_OFS: rd_data = mtimecmp_r;
      CLINT_MTIME_OFS:    rd_data = mtime;
      default:            rd_data = '0;
    endcase
  end

  // mtimecmp resets to all ones so the timer stays quiet
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      mtimecmp_r     <= '1;
      msip_r         <= 1'b0;
      timer_irq_o    <= 1'b0;
      software_irq_o <= 1'b0;
    end
    else
    begin
      if (accept & is_wr & (ofs == CLINT_MTIMECMP_OFS))
        mtimecmp_r <= cmd_i.data;
      if (accept & is_wr & (ofs == CLINT_MSIP_OFS))
        msip_r <= cmd_i.data[0];
      timer_irq_o    <= (mtime >= mtimecmp_r);
      software_irq_o <= msip_r;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_o.op   <= cmd_i.op;
      resp_o.addr <= cmd_i.addr;
      resp_o.data <= is_wr ? '0 : rd_data;
    end
  end

endmodule

`default_nettype wire

// File: io_tile_top.sv
// Tile I/O top level
// Local memory-map dispatcher of the tile with its configuration block,
// CLINT slice and the off-tile memory port.

`timescale 1ns/100ps
`default_nettype none

module io_tile_top
  import io_tile_mem_pkg::*;
  import io_tile_map_pkg::*;
  (input    logic     clk_i
   , input  logic     rst_i

   , input  mem_msg_s cmd_i
   , input  logic     cmd_v_i
   , output logic     cmd_ready_o

   , output mem_msg_s resp_o
   , output logic     resp_v_o
   , input  logic     resp_yumi_i

   , output mem_msg_s mem_cmd_o
   , output logic     mem_cmd_v_o
   , input  logic     mem_cmd_ready_i

   , input  mem_msg_s mem_resp_i
   , input  logic     mem_resp_v_i
   , output logic     mem_resp_yumi_o

   , output cfg_bus_s cfg_bus_o
   , output logic     timer_irq_o
   , output logic     software_irq_o
   );

  logic     cfg_cmd_v;
  logic     cfg_ready;
  mem_msg_s cfg_resp;
  logic     cfg_resp_v;
  logic     cfg_resp_yumi;

  logic     clint_cmd_v;
  logic     clint_ready;
  mem_msg_s clint_resp;
  logic     clint_resp_v;
  logic     clint_resp_yumi;

  mem_cmd_dispatch dispatch_i
    (.cmd_i(cmd_i)
     ,.cmd_v_i(cmd_v_i)
     ,.cmd_ready_o(cmd_ready_o)
     ,.cfg_cmd_v_o(cfg_cmd_v)
     ,.cfg_ready_i(cfg_ready)
     ,.clint_cmd_v_o(clint_cmd_v)
     ,.clint_ready_i(clint_ready)
     ,.mem_cmd_o(mem_cmd_o)
     ,.mem_cmd_v_o(mem_cmd_v_o)
     ,.mem_cmd_ready_i(mem_cmd_ready_i)
     ,.cfg_resp_i(cfg_resp)
     ,.cfg_resp_v_i(cfg_resp_v)
     ,.cfg_resp_yumi_o(cfg_resp_yumi)
     ,.clint_resp_i(clint_resp)
     ,.clint_resp_v_i(clint_resp_v)
     ,.clint_resp_yumi_o(clint_resp_yumi)
     ,.mem_resp_i(mem_resp_i)
     ,.mem_resp_v_i(mem_resp_v_i)
     ,.mem_resp_yumi_o(mem_resp_yumi_o)
     ,.resp_o(resp_o)
     ,.resp_v_o(resp_v_o)
     ,.resp_yumi_i(resp_yumi_i)
     );

  // Devices see the command directly, gated by their own valid
  cfg_regs cfg_i
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.cmd_i(cmd_i)
     ,.cmd_v_i(cfg_cmd_v)
     ,.cmd_ready_o(cfg_ready)
     ,.resp_o(cfg_resp)
     ,.resp_v_o(cfg_resp_v)
     ,.resp_yumi_i(cfg_resp_yumi)
     ,.cfg_bus_o(cfg_bus_o)
     );

  clint_slice clint_i
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.cmd_i(cmd_i)
     ,.cmd_v_i(clint_cmd_v)
     ,.cmd_ready_o(clint_ready)
     ,.resp_o(clint_resp)
     ,.resp_v_o(clint_resp_v)
     ,.resp_yumi_i(clint_resp_yumi)
     ,.timer_irq_o(timer_irq_o)
     ,.software_irq_o(software_irq_o)
     );

endmodule

`default_nettype wire

// File: tb_io_tile_model.svh
// Testbench reference model
// Register state of the cfg block and the CLINT slice, the address decode
// of the dispatcher and a word store standing in for off-tile memory.

`ifndef TB_IO_TILE_MODEL_SVH
`define TB_IO_TILE_MODEL_SVH

logic        m_freeze;
logic [7:0]  m_core_id;
logic        m_cce_mode;
logic        m_msip;
logic [63:0] m_mtimecmp;
logic [63:0] m_mtime_base;
int          m_mtime_cycle;
logic [63:0] m_mem [logic [39:0]];

task automatic reset_model(input int now);
  m_freeze      = 1'b1;
  m_core_id     = '0;
  m_cce_mode    = 1'b0;
  m_msip        = 1'b0;
  m_mtimecmp    = '1;
  m_mtime_base  = '0;
  m_mtime_cycle = now;
endtask

// Local means below the 2 GB boundary with the device field in bits 23:20
function automatic bit addr_is_cfg(input logic [39:0] addr);
  return (addr[39:31] == '0) && (addr[23:20] == 4'd2);
endfunction

function automatic bit addr_is_clint(input logic [39:0] addr);
  return (addr[39:31] == '0) && (addr[23:20] == 4'd1);
endfunction

// Contents of a memory word never written
function automatic logic [63:0] fill_word(input logic [39:0] addr);
  return {addr[39:8], addr[31:0]} ^ 64'hC3A5_5A3C_0F1E_E1F0;
endfunction

task automatic predict(input mem_msg_s c, input int now, output mem_msg_s exp,
                       output bit is_mtime);
  logic [15:0] ofs;
  logic [63:0] rd;
  bit          wr;
  ofs      = c.addr[15:0];
  wr       = (c.op == e_mem_uc_wr);
  rd       = '0;
  is_mtime = 1'b0;
  if (addr_is_cfg(c.addr))
  begin
    if (ofs == CFG_FREEZE_OFS)
    begin
      rd = {63'h0, m_freeze};
      if (wr)
        m_freeze = c.data[0];
    end
    else if (ofs == CFG_CORE_ID_OFS)
    begin
      rd = {56'h0, m_core_id};
      if (wr)
        m_core_id = c.data[7:0];
    end
    else if (ofs == CFG_MODE_OFS)
    begin
      rd = {63'h0, m_cce_mode};
      if (wr)
        m_cce_mode = c.data[0];
    end
  end
  else if (addr_is_clint(c.addr))
  begin
    if (ofs == CLINT_MSIP_OFS)
    begin
      rd = {63'h0, m_msip};
      if (wr)
        m_msip = c.data[0];
    end
    else if (ofs == CLINT_MTIMECMP_OFS)
    begin
      rd = m_mtimecmp;
      if (wr)
        m_mtimecmp = c.data;
    end
    else if (ofs == CLINT_MTIME_OFS)
    begin
      is_mtime = !wr;
      if (wr)
      begin
        m_mtime_base  = c.data;
        m_mtime_cycle = now;
      end
    end
  end
  else if (wr)
    m_mem[c.addr] = c.data;
  else
    rd = m_mem.exists(c.addr) ? m_mem[c.addr] : fill_word(c.addr);
  exp.op   = c.op;
  exp.addr = c.addr;
  exp.data = wr ? '0 : rd;
endtask

`endif

// File: tb_io_tile_top.sv
// Tile I/O testbench
// Seeded random commands to cfg, CLINT and memory are checked in order
// against the reference model. A random-latency responder stands in for
// off-tile memory.

`timescale 1ns/100ps
`default_nettype none

module tb_io_tile_top
  import io_tile_mem_pkg::*;
  import io_tile_map_pkg::*;
  ();

  localparam int N_RANDOM   = 150;
  localparam int N_DIRECTED = 11;
  localparam int LIMIT      = 40 * (N_RANDOM + N_DIRECTED) + 200;

  localparam logic [39:0] CFG_BASE   = 40'h00_0020_0000;
  localparam logic [39:0] CLINT_BASE = 40'h00_0010_0000;

  logic     clk_i;
  logic     rst_i;
  mem_msg_s cmd_i;
  logic     cmd_v_i;
  logic     cmd_ready_o;
  mem_msg_s resp_o;
  logic     resp_v_o;
  logic     resp_yumi_i;
  mem_msg_s mem_cmd_o;
  logic     mem_cmd_v_o;
  logic     mem_cmd_ready_i;
  mem_msg_s mem_resp_i;
  logic     mem_resp_v_i;
  logic     mem_resp_yumi_o;
  cfg_bus_s cfg_bus_o;
  logic     timer_irq_o;
  logic     software_irq_o;

  int       cycle = 0;
  int       n_checks = 0;
  int       n_errors = 0;
  bit       mem_hold;
  bit       mem_take;
  bit       mem_done;
  mem_msg_s mem_taken;
  mem_msg_s pend_q [$];
  int       due_q [$];
  logic [63:0] mem_store [logic [39:0]];

  `include "tb_io_tile_model.svh"

  io_tile_top dut_i
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.cmd_i(cmd_i)
     ,.cmd_v_i(cmd_v_i)
     ,.cmd_ready_o(cmd_ready_o)
     ,.resp_o(resp_o)
     ,.resp_v_o(resp_v_o)
     ,.resp_yumi_i(resp_yumi_i)
     ,.mem_cmd_o(mem_cmd_o)
     ,.mem_cmd_v_o(mem_cmd_v_o)
     ,.mem_cmd_ready_i(mem_cmd_ready_i)
     ,.mem_resp_i(mem_resp_i)
     ,.mem_resp_v_i(mem_resp_v_i)
     ,.mem_resp_yumi_o(mem_resp_yumi_o)
     ,.cfg_bus_o(cfg_bus_o)
     ,.timer_irq_o(timer_irq_o)
     ,.software_irq_o(software_irq_o)
     );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i)
    cycle <= cycle + 1;

  // Memory port handshakes and routing sampled mid-cycle
  always @(negedge clk_i)
  begin
    mem_take  = mem_cmd_v_o && mem_cmd_ready_i;
    mem_taken = mem_cmd_o;
    mem_done  = mem_resp_v_i && mem_resp_yumi_o;
    if (!rst_i && mem_cmd_v_o)
    begin
      n_checks++;
      if (!cmd_v_i || addr_is_cfg(cmd_i.addr) || addr_is_clint(cmd_i.addr)
          || mem_cmd_o !== cmd_i)
      begin
        n_errors++;
        $display("error at %0t: unexpected memory port command %h", $time, mem_cmd_o);
      end
    end
  end

  // Memory responder with 1 to 4 cycles of latency
  always @(posedge clk_i)
  begin
    mem_msg_s reply;
    if (rst_i)
    begin
      mem_cmd_ready_i <= 1'b0;
      mem_resp_v_i    <= 1'b0;
    end
    else
    begin
      if (mem_take)
      begin
        reply.op   = mem_taken.op;
        reply.addr = mem_taken.addr;
        reply.data = '0;
        if (mem_taken.op == e_mem_uc_wr)
          mem_store[mem_taken.addr] = mem_taken.data;
        else if (mem_store.exists(mem_taken.addr))
          reply.data = mem_store[mem_taken.addr];
        else
          reply.data = fill_word(mem_taken.addr);
        pend_q.push_back(reply);
        due_q.push_back(cycle + $urandom_range(4, 1));
      end
      if (mem_done)
      begin
        void'(pend_q.pop_front());
        void'(due_q.pop_front());
        mem_resp_v_i <= 1'b0;
      end
      else if (!mem_resp_v_i && pend_q.size() > 0 && cycle >= due_q[0] && !mem_hold)
      begin
        mem_resp_i   <= pend_q[0];
        mem_resp_v_i <= 1'b1;
      end
      mem_cmd_ready_i <= ($urandom_range(3, 0) != 0);
    end
  end

  function automatic mem_msg_s make_cmd(input mem_op_e op, input logic [39:0] addr,
                                        input logic [63:0] data);
    mem_msg_s c;
    c.op   = op;
    c.addr = addr;
    c.data = data;
    return c;
  endfunction

  function automatic mem_msg_s random_cmd();
    mem_msg_s    c;
    logic [15:0] ofs;
    logic [39:0] base;
    c.op   = mem_op_e'($urandom_range(1, 0));
    c.data = {$urandom, $urandom};
    ofs    = 16'($urandom) & 16'hFFF8;
    case ($urandom_range(2, 0))
      0:
      begin
        case ($urandom_range(3, 0))
          0: ofs = CFG_FREEZE_OFS;
          1: ofs = CFG_CORE_ID_OFS;
          2: ofs = CFG_MODE_OFS;
          default: ofs = ofs;
        endcase
        c.addr = {8'h00, 1'b0, 7'($urandom), 4'h2, 4'($urandom), ofs};
      end
      1:
      begin
        case ($urandom_range(3, 0))
          0: ofs = CLINT_MSIP_OFS;
          1: ofs = CLINT_MTIMECMP_OFS;
          2: ofs = CLINT_MTIME_OFS;
          default: ofs = ofs;
        endcase
        c.addr = {8'h00, 1'b0, 7'($urandom), 4'h1, 4'($urandom), ofs};
        // Keep mtime far from wrapping
        if (ofs == CLINT_MTIME_OFS)
          c.data = {32'h0, $urandom};
      end
      default:
      begin
        case ($urandom_range(3, 0))
          0: base = 40'h00_8000_0000;
          1: base = 40'h12_0000_0000;
          2: base = 40'h00_0030_0000;
          default: base = 40'h00_0000_0000;
        endcase
        c.addr = base | 40'($urandom_range(15, 0) * 8);
      end
    endcase
    return c;
  endfunction

  task automatic send_cmd(input mem_msg_s c, output int t_acc);
    @(posedge clk_i);
    cmd_i   <= c;
    cmd_v_i <= 1'b1;
    @(negedge clk_i);
    while (!cmd_ready_o)
      @(negedge clk_i);
    t_acc = cycle;
    @(posedge clk_i);
    cmd_v_i <= 1'b0;
  endtask

  // Returns after the edge that consumes the response
  task automatic recv_resp(output mem_msg_s r);
    bit done;
    bit shown;
    done = 1'b0;
    while (!done)
    begin
      @(negedge clk_i);
      shown = resp_v_o;
      if (resp_v_o && resp_yumi_i)
      begin
        r    = resp_o;
        done = 1'b1;
      end
      @(posedge clk_i);
      resp_yumi_i <= !done && shown && ($urandom_range(2, 0) != 0);
    end
  endtask

  task automatic check_resp(input mem_msg_s got, input mem_msg_s exp, input bit is_mtime,
                            input int t_acc);
    int          ticks;
    logic [63:0] lo;
    logic [63:0] hi;
    n_checks++;
    // Sampled value lags the elapsed ticks by at most one
    ticks = (t_acc - m_mtime_cycle) / MTIME_DIV;
    lo    = m_mtime_base + 64'(ticks);
    if (ticks > 0)
      lo = lo - 64'd1;
    hi    = m_mtime_base + 64'(ticks) + 64'd1;
    if (got.op !== exp.op || got.addr !== exp.addr)
    begin
      n_errors++;
      $display("error at %0t: response op/addr %b/%h expected %b/%h", $time,
               got.op, got.addr, exp.op, exp.addr);
    end
    if (is_mtime && (got.data < lo || got.data > hi))
    begin
      n_errors++;
      $display("error at %0t: mtime %0d outside %0d..%0d", $time, got.data, lo, hi);
    end
    if (!is_mtime && got.data !== exp.data)
    begin
      n_errors++;
      $display("error at %0t: addr %h data %h expected %h", $time, exp.addr, got.data, exp.data);
    end
  endtask

  task automatic check_state();
    cfg_bus_s want;
    @(negedge clk_i);
    want.freeze   = m_freeze;
    want.core_id  = m_core_id;
    want.cce_mode = m_cce_mode;
    n_checks++;
    if (cfg_bus_o !== want)
    begin
      n_errors++;
      $display("error at %0t: cfg bus %h expected %h", $time, cfg_bus_o, want);
    end
    if (software_irq_o !== m_msip)
    begin
      n_errors++;
      $display("error at %0t: software irq %b expected %b", $time, software_irq_o, m_msip);
    end
    if (m_mtimecmp == '1 && timer_irq_o !== 1'b0)
    begin
      n_errors++;
      $display("error at %0t: timer irq high with mtimecmp all ones", $time);
    end
  endtask

  task automatic run_one(input mem_msg_s c);
    mem_msg_s exp;
    mem_msg_s got;
    bit       is_mtime;
    int       t_acc;
    send_cmd(c, t_acc);
    predict(c, t_acc, exp, is_mtime);
    // Local devices answer one cycle after the accept edge
    if (addr_is_cfg(c.addr) || addr_is_clint(c.addr))
    begin
      @(negedge clk_i);
      if (!resp_v_o)
      begin
        n_errors++;
        $display("error at %0t: no response one cycle after local command", $time);
      end
    end
    recv_resp(got);
    check_resp(got, exp, is_mtime, t_acc);
    check_state();
  endtask

  task automatic check_priority();
    mem_msg_s c_mem;
    mem_msg_s c_cfg;
    mem_msg_s exp_mem;
    mem_msg_s exp_cfg;
    mem_msg_s got;
    bit       is_mtime;
    int       t_acc;
    c_mem = make_cmd(e_mem_uc_rd, 40'h00_8000_0040, '0);
    c_cfg = make_cmd(e_mem_uc_rd, CFG_BASE | 40'(CFG_CORE_ID_OFS), '0);
    @(negedge clk_i);
    mem_hold = 1'b1;
    send_cmd(c_mem, t_acc);
    predict(c_mem, t_acc, exp_mem, is_mtime);
    send_cmd(c_cfg, t_acc);
    predict(c_cfg, t_acc, exp_cfg, is_mtime);
    @(negedge clk_i);
    if (!resp_v_o || resp_o.addr !== c_cfg.addr)
    begin
      n_errors++;
      $display("error at %0t: cfg response not shown while memory is held", $time);
    end
    mem_hold = 1'b0;
    while (!(resp_v_o && resp_o.addr === c_mem.addr))
      @(negedge clk_i);
    recv_resp(got);
    check_resp(got, exp_mem, 1'b0, t_acc);
    recv_resp(got);
    check_resp(got, exp_cfg, 1'b0, t_acc);
    check_state();
  endtask

  initial
  begin
    logic [63:0] x;
    int          i;
    void'($urandom(32'h7381));
    clk_i           = 1'b0;
    rst_i           = 1'b1;
    cmd_i           = '0;
    cmd_v_i         = 1'b0;
    resp_yumi_i     = 1'b0;
    mem_cmd_ready_i = 1'b0;
    mem_resp_i      = '0;
    mem_resp_v_i    = 1'b0;
    mem_hold        = 1'b0;
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    reset_model(cycle);
    n_checks++;
    if (resp_v_o !== 1'b0 || mem_cmd_v_o !== 1'b0 || timer_irq_o !== 1'b0
        || software_irq_o !== 1'b0 || cfg_bus_o !== cfg_bus_s'({1'b1, 8'h00, 1'b0}))
    begin
      n_errors++;
      $display("error at %0t: outputs not at reset values", $time);
    end

    check_priority();

    x = {32'h0, $urandom};
    run_one(make_cmd(e_mem_uc_wr, CLINT_BASE | 40'(CLINT_MTIME_OFS), x));
    for (i = 0; i < 3; i++)
      run_one(make_cmd(e_mem_uc_rd, CLINT_BASE | 40'(CLINT_MTIME_OFS), '0));
    run_one(make_cmd(e_mem_uc_wr, CLINT_BASE | 40'(CLINT_MTIMECMP_OFS), x));
    n_checks++;
    if (timer_irq_o !== 1'b1)
    begin
      n_errors++;
      $display("error at %0t: timer irq low with mtimecmp at or below mtime", $time);
    end
    run_one(make_cmd(e_mem_uc_wr, CLINT_BASE | 40'(CLINT_MTIMECMP_OFS), '1));

    run_one(make_cmd(e_mem_uc_wr, CLINT_BASE | 40'(CLINT_MSIP_OFS), 64'h3));
    run_one(make_cmd(e_mem_uc_rd, CLINT_BASE | 40'(CLINT_MSIP_OFS), '0));
    run_one(make_cmd(e_mem_uc_wr, CLINT_BASE | 40'(CLINT_MSIP_OFS), 64'h2));

    for (i = 0; i < N_RANDOM; i++)
      run_one(random_cmd());

    $display("checks: %0d  errors: %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  initial
  begin
    while (cycle < LIMIT)
      @(posedge clk_i);
    $display("timeout: run did not finish within %0d cycles", LIMIT);
    $display("checks: %0d  errors: %0d", n_checks, n_errors);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: io_tile_top.f
+incdir+.
io_tile_mem_pkg.sv
io_tile_map_pkg.sv
io_slave_fsm.sv
mtime_counter.sv
mem_cmd_dispatch.sv
cfg_regs.sv
clint_slice.sv
io_tile_top.sv
tb_io_tile_top.sv

// File: Bender.yml
package:
  name: io_tile

sources:
  - files:
      - io_tile_mem_pkg.sv
      - io_tile_map_pkg.sv
      - io_slave_fsm.sv
      - mtime_counter.sv
      - mem_cmd_dispatch.sv
      - cfg_regs.sv
      - clint_slice.sv
      - io_tile_top.sv

  - target: test
    include_dirs:
      - .
    files:
      - tb_io_tile_top.sv
